// File: sources.f
logic/spi_route_pkg.sv
logic/spi_input_sync.sv
logic/bit_counter.sv
logic/select_shifter.sv
logic/frame_fsm.sv
logic/port_router.sv
logic/apb_regs.sv
logic/spi_route_top.sv
test/tb_spi_route.sv

// File: run_sim.sh
#!/bin/sh
# Builds the SPI router testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_spi_route -f sources.f -o tb_spi_route
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/tb_spi_route
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

exit 0

// File: test/tb_spi_route.sv
module tb_spi_route;

    timeunit 1ns;
    timeprecision 1ps;

    import spi_route_pkg::*;

    localparam int NUM_PORTS   = 6;
    localparam int HALF_CLKS   = 8;   // SCLK half period in clk cycles.
    localparam int APB_TIMEOUT = 16;
    localparam int IDLE_POLLS  = 16;

    typedef struct packed {
        logic [NUM_PORTS-1:0] route;  // Port that should carry the frame.
        logic [7:0]           miso;
        logic                 grant;
        logic                 reject;
    } frame_exp_t;

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  s_ss;
    logic                  s_sclk;
    logic                  s_mosi;
    logic                  s_miso;
    logic [NUM_PORTS-1:0]  m_ss;
    logic [NUM_PORTS-1:0]  m_sclk;
    logic [NUM_PORTS-1:0]  m_mosi;
    logic [NUM_PORTS-1:0]  m_miso;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [APB_ADDR_W-1:0] paddr;
    logic [APB_DATA_W-1:0] pwdata;
    logic [APB_DATA_W-1:0] prdata;
    logic                  pready;
    logic                  pslverr;

    logic [NUM_PORTS-1:0][7:0]  rx_bytes;
    logic [NUM_PORTS-1:0][15:0] sclk_falls;

    // Reference model state.
    logic [NUM_PORTS-1:0] mask_model;
    logic [CNT_W-1:0]     grants_model;
    logic [CNT_W-1:0]     rejects_model;
    logic [7:0]           last_addr;

    always #50 clk = ~clk;

    spi_route_top #(.NUM_PORTS(NUM_PORTS)) u_spi_route_top (
        .clk(clk), .rst_n(rst_n),
        .s_ss(s_ss), .s_sclk(s_sclk), .s_mosi(s_mosi), .s_miso(s_miso),
        .m_ss(m_ss), .m_sclk(m_sclk), .m_mosi(m_mosi), .m_miso(m_miso),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata),
        .pready(pready), .pslverr(pslverr)
    );

    function automatic logic [7:0] slave_pattern(input int port);
        return 8'hA0 + 8'(port);
    endfunction

    // ============================================================
    // Downstream slave models
    // ============================================================

    for (genvar gi = 0; gi < NUM_PORTS; gi++) begin : g_slave
        logic [7:0]  tx_shift = 8'h00;
        logic [7:0]  rx_shift = 8'h00;
        logic        miso_q   = 1'b0;
        logic [15:0] falls    = 16'd0;

        // Load on select fall, shift out on SCLK fall.
        always @(negedge m_ss[gi] or negedge m_sclk[gi]) begin
            if (!m_ss[gi] && m_sclk[gi]) begin
                tx_shift <= slave_pattern(gi + 1);
            end else if (!m_ss[gi]) begin
                miso_q   <= tx_shift[7];
                tx_shift <= {tx_shift[6:0], 1'b0};
            end
        end

        always @(posedge m_sclk[gi]) begin
            if (!m_ss[gi]) begin
                rx_shift <= {rx_shift[6:0], m_mosi[gi]};
            end
        end

        always @(negedge m_sclk[gi]) begin
            falls <= falls + 16'd1;
        end

        assign m_miso[gi]     = miso_q;
        assign rx_bytes[gi]   = rx_shift;
        assign sclk_falls[gi] = falls;
    end

    // ============================================================
    // Reference and checks
    // ============================================================

    function automatic frame_exp_t predict_frame(input logic [7:0]           addr,
                                                 input logic [NUM_PORTS-1:0] mask);
        frame_exp_t want;
        want        = '0;
        want.reject = 1'b1;  // Unless a rule below claims the frame.
        for (int p = 1; p <= NUM_PORTS; p++) begin
            if (int'(addr) == p && mask[p-1]) begin
                want.route[p-1] = 1'b1;
                want.miso       = slave_pattern(p);
                want.grant      = 1'b1;
                want.reject     = 1'b0;
            end
        end
        if (addr == 8'd7) begin
            want.miso   = 8'hFF;  // Probe.
            want.grant  = 1'b1;
            want.reject = 1'b0;
        end
        return want;
    endfunction

    task automatic stop_run();
        $display("Test FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%02h expected 0x%02h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_reg(input string name, input logic [APB_DATA_W-1:0] got,
                             input logic [APB_DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_ports(input string name, input logic [NUM_PORTS-1:0] got,
                               input logic [NUM_PORTS-1:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_state(input string name, input frame_state_e got,
                               input frame_state_e exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
            stop_run();
        end
    endtask

    // ============================================================
    // Bus drivers
    // ============================================================

    task automatic clocks(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic apb_access(input  logic                  write,
                              input  logic [APB_ADDR_W-1:0] addr,
                              input  logic [APB_DATA_W-1:0] wdata,
                              output logic [APB_DATA_W-1:0] rdata,
                              output logic                  err);
        int waits;
        waits = 0;
        @(posedge clk);
        psel    <= 1'b1;  // Setup phase.
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        while (!pready) begin
            waits++;
            if (waits > APB_TIMEOUT) begin
                $display("APB transfer never completed, pready stayed low");
                stop_run();
            end
            @(negedge clk);
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic expect_reg(input logic [APB_ADDR_W-1:0] addr,
                              input logic [APB_DATA_W-1:0] exp);
        logic [APB_DATA_W-1:0] rdata;
        logic                  err;
        apb_access(1'b0, addr, '0, rdata, err);
        check_bit($sformatf("pslverr @0x%0h", addr), err, 1'b0);
        check_reg($sformatf("prdata @0x%0h", addr), rdata, exp);
    endtask

    task automatic expect_error(input logic write, input logic [APB_ADDR_W-1:0] addr);
        logic [APB_DATA_W-1:0] rdata;
        logic                  err;
        apb_access(write, addr, 32'hFFFF_FFFF, rdata, err);
        check_bit($sformatf("pslverr @0x%0h", addr), err, 1'b1);
    endtask

    task automatic set_mask(input logic [APB_DATA_W-1:0] value);
        logic [APB_DATA_W-1:0] rdata;
        logic                  err;
        apb_access(1'b1, REG_CTRL, value, rdata, err);
        check_bit("pslverr on mask write", err, 1'b0);
        mask_model = value[NUM_PORTS-1:0];  // Upper bits are not stored.
        expect_reg(REG_CTRL, APB_DATA_W'(mask_model));
    endtask

    task automatic wait_idle();
        logic [APB_DATA_W-1:0] status;
        logic                  err;
        int                    polls;
        polls = 0;
        apb_access(1'b0, REG_STATUS, '0, status, err);
        while (frame_state_e'(status[ADDR_BITS +: 3]) != IDLE) begin
            polls++;
            if (polls > IDLE_POLLS) begin
                $display("router never returned to IDLE after select rose");
                stop_run();
            end
            apb_access(1'b0, REG_STATUS, '0, status, err);
        end
    endtask

    // Mode 3 master, one byte MSB first.
    task automatic shift_byte(input  logic [7:0]           tx,
                              output logic [7:0]           rx,
                              output logic [NUM_PORTS-1:0] ss_seen);
        rx      = 8'h00;
        ss_seen = '1;
        for (int b = 7; b >= 0; b--) begin
            @(posedge clk);
            s_sclk <= 1'b0;
            s_mosi <= tx[b];
            clocks(HALF_CLKS - 1);
            @(posedge clk);
            rx      = {rx[6:0], s_miso};  // Sampled on the rising edge.
            ss_seen = m_ss;
            s_sclk <= 1'b1;
            clocks(HALF_CLKS - 1);
        end
    endtask

    task automatic run_frame(input logic [7:0] addr);
        frame_exp_t                 want;
        logic [7:0]                 data;
        logic [7:0]                 miso_byte;
        logic [7:0]                 addr_echo;
        logic [NUM_PORTS-1:0]       ss_addr;
        logic [NUM_PORTS-1:0]       ss_data;
        logic [NUM_PORTS-1:0]       active;
        logic [NUM_PORTS-1:0][15:0] falls_before;
        data         = 8'($urandom);
        want         = predict_frame(addr, mask_model);
        falls_before = sclk_falls;
        @(posedge clk);
        s_ss <= 1'b0;
        clocks(HALF_CLKS);
        shift_byte(addr, addr_echo, ss_addr);
        shift_byte(data, miso_byte, ss_data);
        @(posedge clk);
        s_ss   <= 1'b1;
        s_mosi <= 1'b0;
        wait_idle();
        for (int i = 0; i < NUM_PORTS; i++) begin
            active[i] = (sclk_falls[i] != falls_before[i]);
        end
        check_ports("m_ss during address", ss_addr, '1);
        check_byte("s_miso during address", addr_echo, 8'h00);  // No port or probe yet.
        check_ports("m_ss during data", ss_data, ~want.route);
        check_ports("m_sclk activity", active, want.route);
        check_byte("s_miso", miso_byte, want.miso);
        for (int i = 0; i < NUM_PORTS; i++) begin
            if (want.route[i]) begin
                check_byte("slave rx byte", rx_bytes[i], data);
                check_byte("m_sclk falls", sclk_falls[i][7:0] - falls_before[i][7:0], 8'd8);
            end
        end
        if (want.grant) begin
            grants_model = grants_model + 1'b1;
        end
        if (want.reject) begin
            rejects_model = rejects_model + 1'b1;
        end
        last_addr = addr;
        clocks(4);
    endtask

    // ============================================================
    // Test sequence
    // ============================================================

    initial begin
        logic [APB_DATA_W-1:0] status;
        logic                  err;
        void'($urandom(57));
        rst_n   <= 1'b0;
        s_ss    <= 1'b1;
        s_sclk  <= 1'b1;
        s_mosi  <= 1'b0;
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= '0;
        pwdata  <= '0;
        mask_model    = '1;
        grants_model  = '0;
        rejects_model = '0;
        last_addr     = 8'h00;
        clocks(8);
        rst_n <= 1'b1;
        clocks(2);

        // Reset values, then error responses.
        expect_reg(REG_CTRL, APB_DATA_W'(mask_model));
        expect_reg(REG_STATUS, '0);
        expect_reg(REG_GRANTS, '0);
        expect_reg(REG_REJECTS, '0);
        expect_error(1'b0, 4'h2);
        expect_error(1'b0, 4'h6);
        expect_error(1'b0, 4'hF);
        expect_error(1'b1, 4'hA);
        expect_error(1'b1, REG_STATUS);
        expect_error(1'b1, REG_GRANTS);
        expect_error(1'b1, REG_REJECTS);
        expect_reg(REG_GRANTS, '0);
        set_mask(32'hFFFF_FFC5);
        set_mask(32'h0000_003F);

        for (int p = 1; p <= NUM_PORTS; p++) begin
            run_frame(8'(p));
        end

        set_mask(32'h0000_003B);  // Port 3 off.
        run_frame(8'd3);
        run_frame(8'd4);
        set_mask(32'h0000_003F);

        run_frame(ADDR_PROBE);
        run_frame(ADDR_NONE);
        repeat (4) run_frame(8'($urandom_range(255, 8)));

        // Random mix with one mask change.
        for (int n = 0; n < 12; n++) begin
            if (n == 6) begin
                set_mask(32'($urandom));
            end
            run_frame(8'($urandom_range(9, 0)));
        end
        expect_reg(REG_GRANTS, APB_DATA_W'(grants_model));
        expect_reg(REG_REJECTS, APB_DATA_W'(rejects_model));
        apb_access(1'b0, REG_STATUS, '0, status, err);
        check_bit("pslverr on status read", err, 1'b0);
        check_byte("status last address", status[7:0], last_addr);
        check_state("status state", frame_state_e'(status[ADDR_BITS +: 3]), IDLE);

        $display("Test OK");
        $finish;
    end

endmodule

// File: logic/spi_route_top.sv
module spi_route_top #(
    parameter int NUM_PORTS = 6
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    // Upstream SPI.
    input  logic                                 s_ss,
    input  logic                                 s_sclk,
    input  logic                                 s_mosi,
    output logic                                 s_miso,
    // Downstream SPI.
    output logic [NUM_PORTS-1:0]                 m_ss,
    output logic [NUM_PORTS-1:0]                 m_sclk,
    output logic [NUM_PORTS-1:0]                 m_mosi,
    input  logic [NUM_PORTS-1:0]                 m_miso,
    // APB slave.
    input  logic                                 psel,
    input  logic                                 penable,
    input  logic                                 pwrite,
    input  logic [spi_route_pkg::APB_ADDR_W-1:0] paddr,
    input  logic [spi_route_pkg::APB_DATA_W-1:0] pwdata,
    output logic [spi_route_pkg::APB_DATA_W-1:0] prdata,
    output logic                                 pready,
    output logic                                 pslverr
);

    import spi_route_pkg::*;

    logic                 ss_sync;
    logic                 sclk_rise;
    logic                 mosi_sync;
    logic                 ss_fall;
    logic                 addr_done;
    logic                 addr_phase;
    logic [ADDR_BITS-1:0] addr_byte;
    logic [NUM_PORTS-1:0] grant_port;
    logic                 probe;
    frame_state_e         state;
    logic                 grant_evt;
    logic                 reject_evt;
    logic [NUM_PORTS-1:0] enable_mask;

    // ============================================================
    // Control path, all in the clk domain
    // ============================================================

    spi_input_sync u_spi_input_sync (
        .clk(clk), .rst_n(rst_n),
        .s_ss(s_ss), .s_sclk(s_sclk), .s_mosi(s_mosi),
        .ss_sync(ss_sync), .sclk_rise(sclk_rise),
        .mosi_sync(mosi_sync), .ss_fall(ss_fall)
    );

    bit_counter u_bit_counter (
        .clk(clk), .rst_n(rst_n),
        .ss_sync(ss_sync), .sclk_rise(sclk_rise),
        .addr_done(addr_done)
    );

    select_shifter u_select_shifter (
        .clk(clk), .rst_n(rst_n),
        .ss_fall(ss_fall), .addr_phase(addr_phase),
        .sclk_rise(sclk_rise), .mosi_sync(mosi_sync),
        .addr_byte(addr_byte)
    );

    frame_fsm #(.NUM_PORTS(NUM_PORTS)) u_frame_fsm (
        .clk(clk), .rst_n(rst_n),
        .ss_sync(ss_sync), .ss_fall(ss_fall), .addr_done(addr_done),
        .addr_byte(addr_byte), .enable_mask(enable_mask),
        .addr_phase(addr_phase), .grant_port(grant_port), .probe(probe),
        .state(state), .grant_evt(grant_evt), .reject_evt(reject_evt)
    );

    apb_regs #(.NUM_PORTS(NUM_PORTS)) u_apb_regs (
        .clk(clk), .rst_n(rst_n),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata),
        .addr_byte(addr_byte), .state(state),
        .grant_evt(grant_evt), .reject_evt(reject_evt),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .enable_mask(enable_mask)
    );

    // Data path straight from the pins.
    port_router #(.NUM_PORTS(NUM_PORTS)) u_port_router (
        .s_ss(s_ss), .s_sclk(s_sclk), .s_mosi(s_mosi),
        .grant_port(grant_port), .probe(probe), .m_miso(m_miso),
        .m_ss(m_ss), .m_sclk(m_sclk), .m_mosi(m_mosi),
        .s_miso(s_miso)
    );

endmodule

// File: logic/apb_regs.sv
module apb_regs #(
    parameter int NUM_PORTS = 6
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 psel,
    input  logic                                 penable,
    input  logic                                 pwrite,
    input  logic [spi_route_pkg::APB_ADDR_W-1:0] paddr,
    input  logic [spi_route_pkg::APB_DATA_W-1:0] pwdata,
    input  logic [spi_route_pkg::ADDR_BITS-1:0]  addr_byte,
    input  spi_route_pkg::frame_state_e          state,
    input  logic                                 grant_evt,
    input  logic                                 reject_evt,
    output logic [spi_route_pkg::APB_DATA_W-1:0] prdata,
    output logic                                 pready,
    output logic                                 pslverr,
    output logic [NUM_PORTS-1:0]                 enable_mask
);

    import spi_route_pkg::*;

    logic             access;
    logic             mapped;
    logic             read_only;
    logic [CNT_W-1:0] grant_cnt;
    logic [CNT_W-1:0] reject_cnt;

    assign access = psel & penable;
    assign pready = 1'b1;  // No wait states.

    // ============================================================
    // Read decode
    // ============================================================

    always_comb begin
        mapped = 1'b1;
        prdata = '0;
        case (paddr)
            REG_CTRL: begin
                prdata[NUM_PORTS-1:0] = enable_mask;
            end
            REG_STATUS: begin
                prdata[ADDR_BITS-1:0] = addr_byte;
                prdata[ADDR_BITS +: $bits(frame_state_e)] = state;
            end
            REG_GRANTS: begin
                prdata[CNT_W-1:0] = grant_cnt;
            end
            REG_REJECTS: begin
                prdata[CNT_W-1:0] = reject_cnt;
            end
            default: begin
                mapped = 1'b0;
            end
        endcase
    end

    assign read_only = (paddr != REG_CTRL);
    assign pslverr   = access & (~mapped | (pwrite & read_only));

    // ============================================================
    // Mask and counters
    // ============================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            enable_mask <= '1;  // All ports open.
        end else if (access && pwrite && paddr == REG_CTRL) begin
            enable_mask <= pwdata[NUM_PORTS-1:0];
        end
    end

    // Counters wrap.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            grant_cnt  <= '0;
            reject_cnt <= '0;
        end else begin
            if (grant_evt) begin
                grant_cnt <= grant_cnt + 1'b1;
            end
            if (reject_evt) begin
                reject_cnt <= reject_cnt + 1'b1;
            end
        end
    end

    a_penable_psel: assert property (
        @(posedge clk) disable iff (!rst_n) penable |-> psel
    ) else $error("penable high without psel");

endmodule

// File: logic/port_router.sv
module port_router #(
    parameter int NUM_PORTS = 6
) (
    input  logic                 s_ss,
    input  logic                 s_sclk,
    input  logic                 s_mosi,
    input  logic [NUM_PORTS-1:0] grant_port,
    input  logic                 probe,
    input  logic [NUM_PORTS-1:0] m_miso,
    output logic [NUM_PORTS-1:0] m_ss,
    output logic [NUM_PORTS-1:0] m_sclk,
    output logic [NUM_PORTS-1:0] m_mosi,
    output logic                 s_miso
);

    logic port_miso;

    // Ungranted ports see an idle bus.
    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            m_ss[i]   = grant_port[i] ? s_ss : 1'b1;
            m_sclk[i] = grant_port[i] ? s_sclk : 1'b1;
        end
    end

    assign m_mosi = {NUM_PORTS{s_mosi}};  // Harmless while select is high.

    // Grant is one-hot, so an AND-OR picks the port.
    assign port_miso = |(grant_port & m_miso);
    assign s_miso    = probe | port_miso;

endmodule

// File: logic/frame_fsm.sv
module frame_fsm #(
    parameter int NUM_PORTS = 6
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                ss_sync,
    input  logic                                ss_fall,
    input  logic                                addr_done,
    input  logic [spi_route_pkg::ADDR_BITS-1:0] addr_byte,
    input  logic [NUM_PORTS-1:0]                enable_mask,
    output logic                                addr_phase,
    output logic [NUM_PORTS-1:0]                grant_port,
    output logic                                probe,
    output spi_route_pkg::frame_state_e         state,
    output logic                                grant_evt,
    output logic                                reject_evt
);

    import spi_route_pkg::*;

    frame_state_e         state_next;
    logic [NUM_PORTS-1:0] addr_hit;
    logic                 port_ok;

    // Port n sits on bit n-1.
    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            addr_hit[i] = (addr_byte == ADDR_BITS'(i + 1));
        end
    end

    assign port_ok = |(addr_hit & enable_mask);

    // ============================================================
    // Next state
    // ============================================================

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (ss_fall) begin
                    state_next = ADDR;
                end
            end
            ADDR: begin
                if (addr_done) begin
                    if (port_ok) begin
                        state_next = FORWARD;
                    end else if (addr_byte == ADDR_PROBE) begin
                        state_next = PROBE;
                    end else begin
                        state_next = REJECT;
                    end
                end
            end
            default: begin
                state_next = state;  // Hold until select rises.
            end
        endcase
        if (ss_sync) begin
            state_next = IDLE;
        end
    end

    // ============================================================
    // State and outputs
    // ============================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= IDLE;
            grant_port <= '0;
            probe      <= 1'b0;
            grant_evt  <= 1'b0;
            reject_evt <= 1'b0;
        end else begin
            state <= state_next;
            // Latched at entry, so a mask write mid-frame does not cut it.
            if (state == ADDR && state_next == FORWARD) begin
                grant_port <= addr_hit;
            end else if (state_next != FORWARD) begin
                grant_port <= '0;
            end
            probe      <= (state_next == PROBE);
            grant_evt  <= (state == ADDR) && (state_next == FORWARD || state_next == PROBE);
            reject_evt <= (state == ADDR) && (state_next == REJECT);
        end
    end

    assign addr_phase = (state == ADDR);

    a_grant_onehot: assert property (
        @(posedge clk) disable iff (!rst_n) $onehot0(grant_port)
    ) else $error("more than one downstream port granted");

endmodule

// File: logic/select_shifter.sv
module select_shifter (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                ss_fall,
    input  logic                                addr_phase,
    input  logic                                sclk_rise,
    input  logic                                mosi_sync,
    output logic [spi_route_pkg::ADDR_BITS-1:0] addr_byte
);

    import spi_route_pkg::*;

    // Byte stays put after the address phase for the status register.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_byte <= ADDR_NONE;
        end else if (ss_fall) begin
            addr_byte <= ADDR_NONE;  // New frame.
        end else if (addr_phase && sclk_rise) begin
            addr_byte <= {addr_byte[ADDR_BITS-2:0], mosi_sync};  // MSB first.
        end
    end

endmodule

// File: logic/bit_counter.sv
module bit_counter (
    input  logic clk,
    input  logic rst_n,
    input  logic ss_sync,
    input  logic sclk_rise,
    output logic addr_done
);

    import spi_route_pkg::*;

    localparam int CNT_BITS = $clog2(ADDR_BITS + 1);
    localparam logic [CNT_BITS-1:0] CNT_MAX = CNT_BITS'(ADDR_BITS);

    logic [CNT_BITS-1:0] count;

    // Counts address bits, then holds for the rest of the frame.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (ss_sync) begin
            count <= '0;
        end else if (sclk_rise && count != CNT_MAX) begin
            count <= count + 1'b1;
        end
    end

    assign addr_done = (count == CNT_MAX);

    a_count_range: assert property (
        @(posedge clk) disable iff (!rst_n) count <= CNT_MAX
    ) else $error("bit counter passed the address length");

endmodule

// File: logic/spi_input_sync.sv
module spi_input_sync (
    input  logic clk,
    input  logic rst_n,
    input  logic s_ss,
    input  logic s_sclk,
    input  logic s_mosi,
    output logic ss_sync,
    output logic sclk_rise,
    output logic mosi_sync,
    output logic ss_fall
);

    logic ss_meta;
    logic ss_prev;
    logic sclk_meta;
    logic sclk_sync;
    logic sclk_prev;
    logic mosi_meta;
    logic rise_q;

    // SPI idles high in mode 3, so select and clock reset to one.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ss_meta   <= 1'b1;
            ss_sync   <= 1'b1;
            ss_prev   <= 1'b1;
            sclk_meta <= 1'b1;
            sclk_sync <= 1'b1;
            sclk_prev <= 1'b1;
            mosi_meta <= 1'b0;
            mosi_sync <= 1'b0;
            rise_q    <= 1'b0;
        end else begin
            ss_meta   <= s_ss;
            ss_sync   <= ss_meta;
            ss_prev   <= ss_sync;
            sclk_meta <= s_sclk;
            sclk_sync <= sclk_meta;
            sclk_prev <= sclk_sync;
            mosi_meta <= s_mosi;
            mosi_sync <= mosi_meta;
            rise_q    <= sclk_sync & ~sclk_prev;  // Third cycle after the pin edge.
        end
    end

    assign sclk_rise = rise_q & ~ss_sync;  // No edges outside a frame.
    assign ss_fall   = ss_prev & ~ss_sync;

endmodule

// File: logic/spi_route_pkg.sv
package spi_route_pkg;

    // ============================================================
    // Frame control
    // ============================================================

    typedef enum logic [2:0] {
        IDLE    = 3'd0,  // Select high, waiting for a frame.
        ADDR    = 3'd1,  // Address byte shifting in.
        FORWARD = 3'd2,
        PROBE   = 3'd3,
        REJECT  = 3'd4   // Frame swallowed until select rises.
    } frame_state_e;

    typedef enum logic [7:0] {
        ADDR_NONE  = 8'd0,
        ADDR_PROBE = 8'd7  // Answers with all ones.
    } addr_code_e;

    localparam int unsigned ADDR_BITS = 8;

    // ============================================================
    // APB register map
    // ============================================================

    localparam int unsigned APB_ADDR_W = 4;
    localparam int unsigned APB_DATA_W = 32;
    localparam int unsigned CNT_W      = 16;

    localparam logic [APB_ADDR_W-1:0] REG_CTRL    = 4'h0;  // Port enable mask.
    localparam logic [APB_ADDR_W-1:0] REG_STATUS  = 4'h4;
    localparam logic [APB_ADDR_W-1:0] REG_GRANTS  = 4'h8;
    localparam logic [APB_ADDR_W-1:0] REG_REJECTS = 4'hC;

endpackage
